// File: hdl/jackal_pkg.sv
// Jackal main-CPU glue package holding the bus widths, address map, struct types and select codes
`default_nettype none

package jackal_pkg;

	// ============================================================
	// Widths that carry a meaning on the board
	// ============================================================

	// Main 6809 address and data bus
	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  cpu_data_t;

	// Shared RAM word address, 8 KB deep
	typedef logic [12:0] ram_addr_t;

	// Program ROM byte address covering both EPROMs
	typedef logic [16:0] prog_rom_addr_t;

	// Tilemap colour code where bit 4 flags the layer
	typedef logic [4:0]  color_code_t;

	// Index into the palette RAM
	typedef logic [10:0] pal_index_t;

	// ============================================================
	// Address map and fixed values
	// ============================================================

	// The I/O window is 0x0010 to 0x001F
	localparam cpu_addr_t IO_BASE = 16'h0010;
	localparam cpu_addr_t IO_MASK = 16'hFFF0;

	// Shared work RAM sits above the I/O registers up to 0x1FFF
	localparam cpu_addr_t RAM_LO = 16'h0060;
	localparam cpu_addr_t RAM_HI = 16'h1FFF;

	// Pull-ups leave an undriven bus reading all ones
	localparam cpu_data_t OPEN_BUS = 8'hFF;

	// Bootleg board type that has no blank line to the palette
	localparam logic [1:0] BOOTLEG_NO_BLANK = 2'b01;

	// ============================================================
	// Grouped signals
	// ============================================================

	// Main CPU bus as seen by the glue logic, rw high means read
	typedef struct packed {
		cpu_addr_t addr;
		cpu_data_t wdata;
		logic      rw;
	} cpu_bus_t;

	// Player controls, all active low as on the cabinet harness
	typedef struct packed {
		logic [1:0] coins;
		logic       service;
		logic [1:0] start;
		logic [3:0] p1_joystick;
		logic [3:0] p2_joystick;
		logic [1:0] p1_buttons;
		logic [1:0] p2_buttons;
		logic [7:0] p1_rotary;
		logic [7:0] p2_rotary;
	} player_controls_t;

	// High-score save port that can take over the shared RAM
	typedef struct packed {
		ram_addr_t addr;
		cpu_data_t wdata;
		logic      write;
		logic      access;
	} hiscore_port_t;

	// Bank-switch latch contents
	typedef struct packed {
		logic rom_bank;
		logic zram_bank;
		logic vram_bank;
	} bank_state_t;

	// Which source or sink the main CPU is talking to this cycle
	typedef enum logic [2:0] {
		SEL_NONE,
		SEL_CONTROLS,
		SEL_ROTARY,
		SEL_DIP2,
		SEL_BANK,
		SEL_RAM,
		SEL_ROM
	} bus_sel_e;

endpackage

`default_nettype wire

// File: hdl/clock_enables.sv
// Clock enables, divides clk_49m into pixel and CPU-rate strobes and the main 6809 E/Q pulses
`timescale 1ns/1ps
`default_nettype none

module clock_enables (
	input  wire  clk_49m,
	input  wire  n_sQlat_clr,
	output logic cen_6m,
	output logic cen_3m,
	output logic main_e,
	output logic main_q
);

	// Free-running divider, one full turn is 16 master clocks
	logic [3:0] div;

	// Quarter of the 6809 cycle, advanced on every 6 MHz enable
	logic [1:0] phase;

	// The enables are registered so that they stay low in reset
	// They go high in the cycle where the divider reads zero
	always_ff @(posedge clk_49m or negedge n_sQlat_clr) begin
		if (!n_sQlat_clr) begin
			div    <= 4'd0;
			phase  <= 2'd0;
			cen_6m <= 1'b0;
			cen_3m <= 1'b0;
			main_e <= 1'b0;
			main_q <= 1'b0;
		end else begin
			div    <= div + 4'd1;
			cen_6m <= (div[2:0] == 3'd7);
			cen_3m <= (div == 4'd15);
			// E and Q trail the 6 MHz enable by one clock, half a CPU cycle apart
			main_e <= cen_6m && (phase == 2'b01);
			main_q <= cen_6m && (phase == 2'b11);
			if (cen_6m) begin
				phase <= phase + 2'd1;
			end
		end
	end

	// The CPU core would misbehave if both phase edges landed together
	a_eq_exclusive: assert property (@(posedge clk_49m) disable iff (!n_sQlat_clr)
		!(main_e && main_q));

	// The 3 MHz enable must always coincide with a 6 MHz one
	a_cen_nested: assert property (@(posedge clk_49m) disable iff (!n_sQlat_clr)
		cen_3m |-> cen_6m);

endmodule

`default_nettype wire

// File: hdl/main_bus_ctrl.sv
// Main bus control, decodes the 6809 address and selects the byte returned to the CPU
`timescale 1ns/1ps
`default_nettype none

module main_bus_ctrl (
	input  wire                  clk_49m,
	input  wire                  n_sQlat_clr,
	input  jackal_pkg::cpu_bus_t cpu_bus,
	input  jackal_pkg::cpu_data_t io_rdata,
	input  jackal_pkg::cpu_data_t dip2,
	input  jackal_pkg::cpu_data_t ram_rdata,
	input  jackal_pkg::cpu_data_t rom_rdata,
	output jackal_pkg::bus_sel_e sel,
	output logic                 ram_we,
	output jackal_pkg::cpu_data_t cpu_rdata
);

	logic io_hit;
	logic ram_hit;
	logic rom_hit;

	// Selection of the previous cycle, used to line up the RAM latency
	jackal_pkg::bus_sel_e sel_q;

	// ============================================================
	// Address decode
	// ============================================================

	// I/O registers live where A[15:4] is 0x001
	assign io_hit = ((cpu_bus.addr & jackal_pkg::IO_MASK) == jackal_pkg::IO_BASE);

	assign ram_hit = (cpu_bus.addr >= jackal_pkg::RAM_LO) &&
		(cpu_bus.addr <= jackal_pkg::RAM_HI);

	// Either EPROM answers any read in the upper three quarters of the map
	assign rom_hit = cpu_bus.rw && (cpu_bus.addr[15:14] != 2'b00);

	always_comb begin
		sel = jackal_pkg::SEL_NONE;
		if (io_hit) begin
			// A[3:2] picks the register; the first three are read-only
			case (cpu_bus.addr[3:2])
				2'b00: if (cpu_bus.rw) sel = jackal_pkg::SEL_CONTROLS;
				2'b01: if (cpu_bus.rw) sel = jackal_pkg::SEL_ROTARY;
				2'b10: if (cpu_bus.rw) sel = jackal_pkg::SEL_DIP2;
				default: if (!cpu_bus.rw) sel = jackal_pkg::SEL_BANK;
			endcase
		end else if (ram_hit) begin
			sel = jackal_pkg::SEL_RAM;
		end else if (rom_hit) begin
			sel = jackal_pkg::SEL_ROM;
		end
	end

	// The RAM takes the write at the edge closing this cycle
	assign ram_we = (sel == jackal_pkg::SEL_RAM) && !cpu_bus.rw;

	always_ff @(posedge clk_49m or negedge n_sQlat_clr) begin
		if (!n_sQlat_clr) begin
			sel_q <= jackal_pkg::SEL_NONE;
		end else begin
			sel_q <= sel;
		end
	end

	// ============================================================
	// Read multiplexer
	// ============================================================

	// Registers first, then RAM data from the previous cycle, then ROM
	always_comb begin
		if ((sel == jackal_pkg::SEL_CONTROLS) || (sel == jackal_pkg::SEL_ROTARY)) begin
			cpu_rdata = io_rdata;
		end else if (sel == jackal_pkg::SEL_DIP2) begin
			cpu_rdata = dip2;
		end else if ((sel_q == jackal_pkg::SEL_RAM) && cpu_bus.rw) begin
			cpu_rdata = ram_rdata;
		end else if (sel == jackal_pkg::SEL_ROM) begin
			cpu_rdata = rom_rdata;
		end else begin
			cpu_rdata = jackal_pkg::OPEN_BUS;
		end
	end

	// The bank latch is write-only, a read there must never reach it
	a_bank_write_only: assert property (@(posedge clk_49m) disable iff (!n_sQlat_clr)
		(sel == jackal_pkg::SEL_BANK) |-> !cpu_bus.rw);

endmodule

`default_nettype wire

// File: hdl/player_inputs.sv
// Player inputs, builds the control, DIP and rotary bytes read by the main CPU
`timescale 1ns/1ps
`default_nettype none

module player_inputs (
	input  wire        [1:0]          addr_lo,
	input  jackal_pkg::bus_sel_e      sel,
	input  jackal_pkg::player_controls_t controls,
	input  wire        [19:0]         dipsw,
	output jackal_pkg::cpu_data_t     io_rdata
);

	// The control register shares its four bytes with DIP banks 1 and 3
	// The rotary register only has two bytes, the rest float high
	always_comb begin
		io_rdata = jackal_pkg::OPEN_BUS;
		case (sel)
			jackal_pkg::SEL_CONTROLS: begin
				case (addr_lo)
					2'b00: io_rdata = dipsw[7:0];
					// Bit 6 has no switch fitted and reads high
					2'b01: io_rdata = {dipsw[19], 1'b1, controls.p1_buttons,
						controls.p1_joystick};
					2'b10: io_rdata = {2'b11, controls.p2_buttons, controls.p2_joystick};
					default: io_rdata = {dipsw[18:16], controls.start, controls.service,
						controls.coins};
				endcase
			end
			jackal_pkg::SEL_ROTARY: begin
				case (addr_lo)
					2'b00: io_rdata = controls.p1_rotary;
					2'b01: io_rdata = controls.p2_rotary;
					default: io_rdata = jackal_pkg::OPEN_BUS;
				endcase
			end
			default: io_rdata = jackal_pkg::OPEN_BUS;
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/rom_banking.sv
// ROM banking, holds the bank-switch latch and registers the program ROM address
`timescale 1ns/1ps
`default_nettype none

module rom_banking (
	input  wire                        clk_49m,
	input  wire                        n_sQlat_clr,
	input  wire                        cen_3m,
	input  jackal_pkg::cpu_bus_t       cpu_bus,
	input  jackal_pkg::bus_sel_e       sel,
	output jackal_pkg::bank_state_t    bank_state,
	output jackal_pkg::prog_rom_addr_t prog_rom_addr
);

	jackal_pkg::prog_rom_addr_t rom_addr_next;

	// ============================================================
	// Bank latch
	// ============================================================

	// The latch is clocked at the 3 MHz rate like the board's LS chip
	always_ff @(posedge clk_49m or negedge n_sQlat_clr) begin
		if (!n_sQlat_clr) begin
			bank_state <= '0;
		end else if (cen_3m && (sel == jackal_pkg::SEL_BANK)) begin
			bank_state.rom_bank  <= cpu_bus.wdata[5];
			bank_state.zram_bank <= cpu_bus.wdata[4];
			bank_state.vram_bank <= cpu_bus.wdata[3];
		end
	end

	// ============================================================
	// Program ROM address
	// ============================================================

	// 0xC000 and up maps onto the fixed second EPROM at the top
	// Below that the first EPROM is banked in 32 KB halves
	// A14 is inverted so 0x4000 starts the lower half of a bank
	assign rom_addr_next = {
		cpu_bus.addr[15:14] == 2'b11,
		(cpu_bus.addr[15:14] != 2'b11) & bank_state.rom_bank,
		~cpu_bus.addr[14],
		cpu_bus.addr[13:0]
	};

	// The address holds between ROM reads so the external memory stays quiet
	always_ff @(posedge clk_49m) begin
		if (sel == jackal_pkg::SEL_ROM) begin
			prog_rom_addr <= rom_addr_next;
		end
	end

endmodule

`default_nettype wire

// File: hdl/shared_ram.sv
// Shared RAM, 8 KB main CPU work memory that the high-score port can take over
`timescale 1ns/1ps
`default_nettype none

module shared_ram (
	input  wire                       clk_49m,
	input  jackal_pkg::ram_addr_t     cpu_addr,
	input  jackal_pkg::cpu_data_t     cpu_wdata,
	input  wire                       ram_we,
	input  jackal_pkg::hiscore_port_t hiscore,
	output jackal_pkg::cpu_data_t     ram_rdata,
	output jackal_pkg::cpu_data_t     hs_data_out
);

	localparam int DEPTH = 2 ** $bits(jackal_pkg::ram_addr_t);

	jackal_pkg::cpu_data_t mem [DEPTH];

	jackal_pkg::ram_addr_t mem_addr;
	jackal_pkg::cpu_data_t mem_wdata;
	logic                  mem_we;
	jackal_pkg::cpu_data_t mem_q;

	// While the high-score port is active the CPU loses the RAM entirely
	assign mem_addr  = hiscore.access ? hiscore.addr  : cpu_addr;
	assign mem_wdata = hiscore.access ? hiscore.wdata : cpu_wdata;
	assign mem_we    = hiscore.access ? hiscore.write : ram_we;

	// Single port, read data comes out one clock after the address
	always_ff @(posedge clk_49m) begin
		if (mem_we) begin
			mem[mem_addr] <= mem_wdata;
		end
		mem_q <= mem[mem_addr];
	end

	// Only the side that owns the RAM sees its data, the other reads zero
	assign ram_rdata   = hiscore.access ? 8'h00 : mem_q;
	assign hs_data_out = hiscore.access ? mem_q : 8'h00;

	// A CPU write during a high-score save would be silently dropped
	a_single_writer: assert property (@(posedge clk_49m)
		!(hiscore.access && hiscore.write && ram_we));

endmodule

`default_nettype wire

// File: hdl/color_merge.sv
// Colour merge, combines the two tilemap colour codes into a palette index and blank flag
`timescale 1ns/1ps
`default_nettype none

module color_merge (
	input  wire                     clk_49m,
	input  wire                     n_sQlat_clr,
	input  jackal_pkg::color_code_t main_color,
	input  jackal_pkg::color_code_t sec_color,
	input  wire        [1:0]        is_bootleg,
	output jackal_pkg::pal_index_t  pal_index,
	output logic                    blank
);

	logic       color_sel;
	logic [3:0] low_nibble;
	logic [7:0] color_byte;
	logic       blank_next;

	// Both layer flags set picks the upper palette half
	assign color_sel = main_color[4] & sec_color[4];

	// With only the main flag set the secondary chip shows through
	assign low_nibble = main_color[4] ? sec_color[3:0] : main_color[3:0];

	assign color_byte = color_sel ? {main_color[3:0], sec_color[3:0]} :
		{3'b000, main_color[4], low_nibble};

	// Blank goes low when both chips output colour zero
	// Bootleg boards never blank
	assign blank_next = (is_bootleg == jackal_pkg::BOOTLEG_NO_BLANK) ? 1'b1 :
		((|main_color[3:0]) | (|sec_color[3:0]));

	always_ff @(posedge clk_49m or negedge n_sQlat_clr) begin
		if (!n_sQlat_clr) begin
			pal_index <= '0;
			blank     <= 1'b0;
		end else begin
			pal_index <= {2'b00, color_sel, color_byte[7], color_byte[6:0]};
			blank     <= blank_next;
		end
	end

endmodule

`default_nettype wire

// File: hdl/jackal_core.sv
// Jackal core, main-CPU glue logic of the arcade board tying the blocks together
`timescale 1ns/1ps
`default_nettype none

module jackal_core (
	input  wire                          clk_49m,
	input  wire                          n_sQlat_clr,
	input  jackal_pkg::cpu_bus_t         cpu_bus,
	input  jackal_pkg::player_controls_t controls,
	input  wire        [19:0]            dipsw,
	input  jackal_pkg::hiscore_port_t    hiscore,
	input  wire        [1:0]             is_bootleg,
	input  jackal_pkg::color_code_t      main_color,
	input  jackal_pkg::color_code_t      sec_color,
	input  jackal_pkg::cpu_data_t        prog_rom_do,
	output jackal_pkg::cpu_data_t        cpu_rdata,
	output jackal_pkg::prog_rom_addr_t   prog_rom_addr,
	output jackal_pkg::bank_state_t      bank_state,
	output jackal_pkg::cpu_data_t        hs_data_out,
	output jackal_pkg::pal_index_t       pal_index,
	output wire                          blank,
	output wire                          cen_6m,
	output wire                          cen_3m,
	output wire                          main_e,
	output wire                          main_q
);

	jackal_pkg::bus_sel_e  sel;
	jackal_pkg::cpu_data_t io_rdata;
	jackal_pkg::cpu_data_t ram_rdata;
	wire                   ram_we;

	// ============================================================
	// Timing
	// ============================================================

	clock_enables u_clock_enables (
		.clk_49m     (clk_49m),
		.n_sQlat_clr (n_sQlat_clr),
		.cen_6m      (cen_6m),
		.cen_3m      (cen_3m),
		.main_e      (main_e),
		.main_q      (main_q)
	);

	// ============================================================
	// Main CPU bus
	// ============================================================

	// DIP bank 2 has its own register and goes straight to the mux
	main_bus_ctrl u_main_bus_ctrl (
		.clk_49m     (clk_49m),
		.n_sQlat_clr (n_sQlat_clr),
		.cpu_bus     (cpu_bus),
		.io_rdata    (io_rdata),
		.dip2        (dipsw[15:8]),
		.ram_rdata   (ram_rdata),
		.rom_rdata   (prog_rom_do),
		.sel         (sel),
		.ram_we      (ram_we),
		.cpu_rdata   (cpu_rdata)
	);

	player_inputs u_player_inputs (
		.addr_lo  (cpu_bus.addr[1:0]),
		.sel      (sel),
		.controls (controls),
		.dipsw    (dipsw),
		.io_rdata (io_rdata)
	);

	rom_banking u_rom_banking (
		.clk_49m       (clk_49m),
		.n_sQlat_clr   (n_sQlat_clr),
		.cen_3m        (cen_3m),
		.cpu_bus       (cpu_bus),
		.sel           (sel),
		.bank_state    (bank_state),
		.prog_rom_addr (prog_rom_addr)
	);

	// The RAM decodes only the low 13 address lines
	shared_ram u_shared_ram (
		.clk_49m     (clk_49m),
		.cpu_addr    (cpu_bus.addr[12:0]),
		.cpu_wdata   (cpu_bus.wdata),
		.ram_we      (ram_we),
		.hiscore     (hiscore),
		.ram_rdata   (ram_rdata),
		.hs_data_out (hs_data_out)
	);

	// ============================================================
	// Video colour path
	// ============================================================

	color_merge u_color_merge (
		.clk_49m     (clk_49m),
		.n_sQlat_clr (n_sQlat_clr),
		.main_color  (main_color),
		.sec_color   (sec_color),
		.is_bootleg  (is_bootleg),
		.pal_index   (pal_index),
		.blank       (blank)
	);

endmodule

`default_nettype wire

// File: verification/tb_jackal_tests.svh
// Directed tests for the Jackal glue logic that each drive the DUT and check its response
`ifndef TB_JACKAL_TESTS_SVH
`define TB_JACKAL_TESTS_SVH

	// Reference copy of what the CPU wrote into the shared RAM
	logic [7:0] ram_model [0:8191];

	// Control register bytes as wired on the cabinet harness
	function automatic logic [7:0] control_byte(input logic [1:0] lo);
		case (lo)
			2'd0: return dipsw[7:0];
			2'd1: return {dipsw[19], 1'b1, controls.p1_buttons, controls.p1_joystick};
			2'd2: return {2'b11, controls.p2_buttons, controls.p2_joystick};
			default: return {dipsw[18:16], controls.start, controls.service, controls.coins};
		endcase
	endfunction

	function automatic logic [7:0] rotary_byte(input logic [1:0] lo);
		case (lo)
			2'd0: return controls.p1_rotary;
			2'd1: return controls.p2_rotary;
			default: return 8'hFF;
		endcase
	endfunction

	// Upper bit is the blank flag and the rest is the palette index
	// Both layer flags together select the upper palette half with both nibbles
	// With the main flag alone the secondary nibble shows through
	function automatic logic [11:0] merge_colour(input logic [4:0] m, input logic [4:0] s,
		input logic [1:0] bootleg);
		logic [10:0] idx;
		logic        bl;
		case ({m[4], s[4]})
			2'b11:   idx = {3'b001, m[3:0], s[3:0]};
			2'b10:   idx = {7'b0000001, s[3:0]};
			default: idx = {7'b0000000, m[3:0]};
		endcase
		if (bootleg == 2'b01) begin
			bl = 1'b1;
		end else begin
			bl = (m[3:0] != 4'h0) || (s[3:0] != 4'h0);
		end
		return {bl, idx};
	endfunction

	task automatic track_pulse(input logic pulse, input int cyc, input int period,
		input string name, inout int last, inout int count);
		if (pulse) begin
			if (last >= 0) begin
				expect_eq(32'(cyc - last), 32'(period), {name, " spacing"});
			end
			last = cyc;
			count++;
		end
	endtask

	task automatic test_enables();
		int errs;
		int last_6m;
		int last_3m;
		int last_e;
		int last_q;
		int n_6m;
		int n_3m;
		int n_e;
		int n_q;
		errs    = error_count;
		last_6m = -1;
		last_3m = -1;
		last_e  = -1;
		last_q  = -1;
		n_6m    = 0;
		n_3m    = 0;
		n_e     = 0;
		n_q     = 0;
		for (int cyc = 0; cyc < 256; cyc++) begin
			@(negedge clk_49m);
			// E and Q sit half a CPU cycle apart
			if (main_q && (last_e >= 0)) begin
				expect_eq(32'(cyc - last_e), 32'd16, "main_q after main_e");
			end
			if (main_e && (last_q >= 0)) begin
				expect_eq(32'(cyc - last_q), 32'd16, "main_e after main_q");
			end
			track_pulse(cen_6m, cyc, 8, "cen_6m", last_6m, n_6m);
			track_pulse(cen_3m, cyc, 16, "cen_3m", last_3m, n_3m);
			track_pulse(main_e, cyc, 32, "main_e", last_e, n_e);
			track_pulse(main_q, cyc, 32, "main_q", last_q, n_q);
		end
		expect_eq(32'(n_6m >= 31), 32'd1, "cen_6m pulse count");
		expect_eq(32'(n_3m >= 15), 32'd1, "cen_3m pulse count");
		expect_eq(32'(n_e >= 7), 32'd1, "main_e pulse count");
		expect_eq(32'(n_q >= 7), 32'd1, "main_q pulse count");
		finish_test("enables", errs);
	endtask

	task automatic test_inputs();
		int          errs;
		logic [31:0] r1;
		logic [31:0] r2;
		logic [7:0]  got;
		errs = error_count;
		for (int iter = 0; iter < 4; iter++) begin
			r1 = $random(seed);
			r2 = $random(seed);
			@(posedge clk_49m);
			controls <= jackal_pkg::player_controls_t'({r1[0], r2});
			dipsw    <= r1[20:1];
			for (int lo = 0; lo < 4; lo++) begin
				cpu_read(16'h0010 + 16'(lo), got);
				expect_eq(32'(got), 32'(control_byte(2'(lo))), "control register read");
				cpu_read(16'h0014 + 16'(lo), got);
				expect_eq(32'(got), 32'(rotary_byte(2'(lo))), "rotary register read");
			end
			cpu_read(16'h0018, got);
			expect_eq(32'(got), 32'(dipsw[15:8]), "DIP bank 2 read");
		end
		finish_test("inputs", errs);
	endtask

	task automatic test_banking();
		int          errs;
		logic [31:0] r;
		logic [7:0]  wbyte;
		logic [15:0] addr;
		logic [16:0] exp_addr;
		logic [7:0]  got;
		errs = error_count;
		expect_eq(32'(bank_state), 32'd0, "bank latch after reset");
		for (int round = 0; round < 2; round++) begin
			r     = $random(seed);
			wbyte = r[7:0];
			// Both ROM bank values get their turn
			wbyte[5] = (round == 0);
			cpu_write(16'h001C, wbyte, 16);
			@(negedge clk_49m);
			expect_eq(32'(bank_state), 32'(wbyte[5:3]), "bank latch contents");
			for (int n = 0; n < 8; n++) begin
				r    = $random(seed);
				addr = {2'd1 + (r[17:16] % 2'd3), r[13:0]};
				@(posedge clk_49m);
				prog_rom_do <= r[31:24];
				cpu_read(addr, got);
				// The fixed EPROM answers the top quarter and the banked one the middle half
				case (addr[15:14])
					2'b11:   exp_addr = {3'b100, addr[13:0]};
					2'b10:   exp_addr = {1'b0, wbyte[5], 1'b1, addr[13:0]};
					default: exp_addr = {1'b0, wbyte[5], 1'b0, addr[13:0]};
				endcase
				expect_eq(32'(prog_rom_addr), 32'(exp_addr), "program ROM address");
				expect_eq(32'(got), 32'(r[31:24]), "ROM data to CPU");
			end
		end
		finish_test("banking", errs);
	endtask

	task automatic test_shared_ram();
		int          errs;
		logic [31:0] r;
		logic [15:0] addrs [16];
		logic [7:0]  got;
		errs = error_count;
		for (int n = 0; n < 16; n++) begin
			r        = $random(seed);
			addrs[n] = 16'h0060 + (r[15:0] % 16'h1FA0);
			ram_model[addrs[n][12:0]] = r[23:16];
			cpu_write(addrs[n], r[23:16], 1);
		end
		for (int n = 0; n < 16; n++) begin
			cpu_read(addrs[n], got);
			expect_eq(32'(got), 32'(ram_model[addrs[n][12:0]]), "shared RAM read back");
		end
		// The gap below the RAM has nothing fitted
		for (int n = 0; n < 8; n++) begin
			r = $random(seed);
			cpu_read(16'h0020 + 16'(r[5:0]), got);
			expect_eq(32'(got), 32'hFF, "unmapped read");
		end
		finish_test("shared_ram", errs);
	endtask

	task automatic test_hiscore();
		int          errs;
		logic [31:0] r;
		logic [15:0] addr;
		logic [7:0]  data;
		logic [7:0]  got;
		errs = error_count;
		r    = $random(seed);
		addr = 16'h0060 + (r[15:0] % 16'h1FA0);
		data = r[23:16] | 8'h01;
		@(posedge clk_49m);
		hiscore <= '{addr: addr[12:0], wdata: data, write: 1'b1, access: 1'b1};
		@(posedge clk_49m);
		hiscore.write <= 1'b0;
		@(posedge clk_49m);
		@(negedge clk_49m);
		expect_eq(32'(hs_data_out), 32'(data), "high-score read back");
		cpu_read(addr, got);
		expect_eq(32'(got), 32'h00, "CPU read during high-score access");
		@(posedge clk_49m);
		hiscore.access <= 1'b0;
		@(negedge clk_49m);
		expect_eq(32'(hs_data_out), 32'h00, "high-score output without access");
		cpu_read(addr, got);
		expect_eq(32'(got), 32'(data), "CPU read after high-score access");
		finish_test("hiscore", errs);
	endtask

	task automatic test_colour();
		int          errs;
		logic [31:0] r;
		logic [11:0] exp;
		errs = error_count;
		for (int n = 0; n < 32; n++) begin
			r = $random(seed);
			@(posedge clk_49m);
			main_color <= r[4:0];
			sec_color  <= r[9:5];
			is_bootleg <= r[11:10];
			@(posedge clk_49m);
			@(negedge clk_49m);
			exp = merge_colour(r[4:0], r[9:5], r[11:10]);
			expect_eq(32'(pal_index), 32'(exp[10:0]), "palette index");
			expect_eq(32'(blank), 32'(exp[11]), "blank flag");
		end
		finish_test("colour", errs);
	endtask

`endif

// File: verification/tb_jackal_core.sv
// Testbench for the Jackal main-CPU glue logic with clock, reset, watchdog, bus helpers and summary
`timescale 1ns/1ps
`default_nettype none

module tb_jackal_core;

	// The tests take roughly 580 cycles in all
	// Enables take 256, inputs 80, banking 85, RAM 80, high score 10 and colour 64
	// A limit of 4000 cycles leaves a wide margin
	localparam int WATCHDOG_CYCLES = 4000;

	logic                         clk_49m;
	logic                         n_sQlat_clr;
	jackal_pkg::cpu_bus_t         cpu_bus;
	jackal_pkg::player_controls_t controls;
	logic [19:0]                  dipsw;
	jackal_pkg::hiscore_port_t    hiscore;
	logic [1:0]                   is_bootleg;
	jackal_pkg::color_code_t      main_color;
	jackal_pkg::color_code_t      sec_color;
	jackal_pkg::cpu_data_t        prog_rom_do;
	jackal_pkg::cpu_data_t        cpu_rdata;
	jackal_pkg::prog_rom_addr_t   prog_rom_addr;
	jackal_pkg::bank_state_t      bank_state;
	jackal_pkg::cpu_data_t        hs_data_out;
	jackal_pkg::pal_index_t       pal_index;
	logic                         blank;
	logic                         cen_6m;
	logic                         cen_3m;
	logic                         main_e;
	logic                         main_q;

	integer seed;
	int     error_count;
	int     check_count;
	int     test_count;

	jackal_core uut (
		.clk_49m       (clk_49m),
		.n_sQlat_clr   (n_sQlat_clr),
		.cpu_bus       (cpu_bus),
		.controls      (controls),
		.dipsw         (dipsw),
		.hiscore       (hiscore),
		.is_bootleg    (is_bootleg),
		.main_color    (main_color),
		.sec_color     (sec_color),
		.prog_rom_do   (prog_rom_do),
		.cpu_rdata     (cpu_rdata),
		.prog_rom_addr (prog_rom_addr),
		.bank_state    (bank_state),
		.hs_data_out   (hs_data_out),
		.pal_index     (pal_index),
		.blank         (blank),
		.cen_6m        (cen_6m),
		.cen_3m        (cen_3m),
		.main_e        (main_e),
		.main_q        (main_q)
	);

	// 8 ns period
	initial begin
		clk_49m = 1'b0;
		forever #4 clk_49m = ~clk_49m;
	end

	// ============================================================
	// Check and bus helpers
	// ============================================================

	task automatic expect_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		check_count++;
		assert (got === exp) else begin
			$display("Fail at %0d ns: %s, got %0h, expected %0h", $time, what, got, exp);
			error_count++;
		end
	endtask

	// Reads span two clocks so the RAM latency and any stale selection have cleared
	task automatic cpu_read(input logic [15:0] addr, output logic [7:0] data);
		@(posedge clk_49m);
		cpu_bus.addr  <= addr;
		cpu_bus.wdata <= 8'h00;
		cpu_bus.rw    <= 1'b1;
		@(posedge clk_49m);
		@(negedge clk_49m);
		data = cpu_rdata;
	endtask

	// The write is held for a number of clocks, then the bus parks on an unmapped read
	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data, input int hold);
		@(posedge clk_49m);
		cpu_bus.addr  <= addr;
		cpu_bus.wdata <= data;
		cpu_bus.rw    <= 1'b0;
		repeat (hold) @(posedge clk_49m);
		cpu_bus.addr <= 16'h0000;
		cpu_bus.rw   <= 1'b1;
	endtask

	task automatic finish_test(input string name, input int errors_before);
		test_count++;
		if (error_count == errors_before) begin
			$display("Test %s passed", name);
		end else begin
			$display("Test %s failed with %0d errors", name, error_count - errors_before);
		end
	endtask

	`include "tb_jackal_tests.svh"

	// ============================================================
	// Sequence and summary
	// ============================================================

	initial begin
		seed        = 32'hc3a9754f;
		error_count = 0;
		check_count = 0;
		test_count  = 0;
		n_sQlat_clr <= 1'b0;
		cpu_bus     <= '{addr: 16'h0000, wdata: 8'h00, rw: 1'b1};
		controls    <= '1;
		dipsw       <= '1;
		hiscore     <= '0;
		is_bootleg  <= 2'b00;
		main_color  <= '0;
		sec_color   <= '0;
		prog_rom_do <= 8'h00;
		repeat (3) @(posedge clk_49m);
		n_sQlat_clr <= 1'b1;

		test_enables();
		test_inputs();
		test_banking();
		test_shared_ram();
		test_hiscore();
		test_colour();

		$display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
			error_count);
		if (error_count == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	// A stuck test ends the run here
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_49m);
		$display("Watchdog expired after %0d cycles, the tests did not complete",
			WATCHDOG_CYCLES);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: jackal_core.f
+incdir+verification
hdl/jackal_pkg.sv
hdl/clock_enables.sv
hdl/main_bus_ctrl.sv
hdl/player_inputs.sv
hdl/rom_banking.sv
hdl/shared_ram.sv
hdl/color_merge.sv
hdl/jackal_core.sv
verification/tb_jackal_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log for a reported failure
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module tb_jackal_core -f jackal_core.f \
	&& ./obj_dir/Vtb_jackal_core 2>&1 | tee sim.log \
	|| { echo "Verilator build or simulation run failed"; exit 1; }

grep -q "Simulation finished: FAIL" sim.log \
	&& { echo "Testbench reported a failure"; exit 1; }
grep -q "Simulation finished: PASS" sim.log \
	|| { echo "Simulation ended without a result line"; exit 1; }
exit 0
